// ==== hw/cart_io_pkg.sv ====
/*
 * Shared types and constants for the cartridge and game-port control core.
 * Pad words, the DB9 mode enum, the cheat record layout and the backup RAM
 * command word all live here. Other files reach them by scoped names.
 */

package cart_io_pkg;

	// ========================================================================
	// Pads and DB9
	// ========================================================================

	localparam int PAD_BITS  = 7;
	localparam int DB9_BITS  = 6;     // tr, tl, up, down, left, right
	localparam int PAD_COUNT = 4;

	localparam int SPLIT_PERIOD = 256; // Clocks between splitter captures

	localparam int TAP_TMR_BITS = 16;
	localparam logic [TAP_TMR_BITS-1:0] TAP_TIMEOUT = 16'd57000; // ce_cpu ticks

	// Positive logic, 1 = pressed
	typedef struct packed {
		logic pause;
		logic tr;
		logic tl;
		logic up;
		logic down;
		logic left;
		logic right;
	} pad_t;

	typedef enum logic [1:0] {
		DB9_P1    = 2'd0,
		DB9_P2    = 2'd1,
		DB9_SPLIT = 2'd2,
		DB9_OFF   = 2'd3
	} db9_mode_e;

	typedef struct packed {
		db9_mode_e db9_mode;
		logic      swap;        // Exchange pads 0 and 1
		logic      multitap_en; // Four pads on port A
	} pad_cfg_t;

	// ========================================================================
	// Cheat records
	// ========================================================================

	typedef struct packed {
		logic       wr;
		logic       code_sel;   // Download targets the cheat slot
		logic [3:0] addr;
		logic [7:0] data;
	} byte_load_t;

	// Each field is little-endian, replace sits at the bottom
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_fields_t;

	// Byte n of the download lands on bits 8n+7..8n
	typedef union packed {
		logic [15:0][7:0] bytes;
		cheat_fields_t    fields;
	} cheat_rec_u;

	// ========================================================================
	// Backup RAM
	// ========================================================================

	localparam int SECTORS  = 64;
	localparam int LBA_BITS = 6;

	typedef struct packed {
		logic load;
		logic save;
	} bk_req_t;

	typedef struct packed {
		logic [LBA_BITS-1:0] lba;
		logic                rd;
		logic                wr;
	} sd_cmd_t;

endpackage

// ==== hw/pad_router.sv ====
/*
 * Routes host pads and the DB9 joystick to the two console ports.
 * In splitter mode two DB9 pads are sampled alternately on one connector.
 * Port words are registered and negative logic (1 = released).
 */

module pad_router (
	input  logic                                           clk_sys,
	input  logic                                           rst_n,
	input  cart_io_pkg::pad_cfg_t                          cfg,
	input  cart_io_pkg::pad_t [cart_io_pkg::PAD_COUNT-1:0] pads,
	input  logic [cart_io_pkg::DB9_BITS-1:0]               db9,
	input  logic [1:0]                                     pad_idx,
	output cart_io_pkg::pad_t                              port_a,
	output cart_io_pkg::pad_t                              port_b,
	output logic                                           splitter_select
);

	logic [$clog2(cart_io_pkg::SPLIT_PERIOD)-1:0] prescale;
	logic [cart_io_pkg::DB9_BITS-1:0]             split_p1, split_p2;
	logic [cart_io_pkg::DB9_BITS-1:0]             db_p1, db_p2;
	cart_io_pkg::pad_t [cart_io_pkg::PAD_COUNT-1:0] merged, routed;

	// ========================================================================
	// Splitter capture
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			prescale        <= '0;
			split_p1        <= '0;
			split_p2        <= '0;
			splitter_select <= 1'b1;
		end else if (cfg.db9_mode == cart_io_pkg::DB9_SPLIT) begin
			prescale <= prescale + 1'b1;
			if (&prescale) begin // Wrap
				if (splitter_select)
					split_p1 <= db9;
				else
					split_p2 <= db9;
				splitter_select <= ~splitter_select;
			end
		end
	end

	// ========================================================================
	// Merge and swap
	// ========================================================================

	always_comb begin
		db_p1 = '0;
		db_p2 = '0;
		case (cfg.db9_mode)
			cart_io_pkg::DB9_P1:    db_p1 = db9;
			cart_io_pkg::DB9_P2:    db_p2 = db9;
			cart_io_pkg::DB9_SPLIT: begin
				db_p1 = split_p1;
				db_p2 = split_p2;
			end
			default: ;              // DB9 unused
		endcase

		merged    = pads;
		merged[0] = cart_io_pkg::pad_t'(pads[0] | {1'b0, db_p1});
		merged[1] = cart_io_pkg::pad_t'(pads[1] | {1'b0, db_p2});

		routed = merged;
		if (cfg.swap) begin
			routed[0] = merged[1];
			routed[1] = merged[0];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			port_a <= '1; // All released
			port_b <= '1;
		end else begin
			port_a <= ~routed[pad_idx];
			port_b <= cfg.multitap_en ? '1 : ~routed[1]; // Tap owns both ports
		end
	end

endmodule

// ==== hw/multitap_timer.sv ====
/*
 * Multitap pad selector. Each TH falling edge steps to the next pad, and a
 * long TH-high period restarts the scan at pad 0. Everything is sampled
 * on ce_cpu ticks.
 */

module multitap_timer (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       ce_cpu,
	input  logic       th,
	input  logic       multitap_en,
	output logic [1:0] pad_idx
);

	logic [cart_io_pkg::TAP_TMR_BITS-1:0] tmr; // TH high time
	logic                                 th_d;
	logic                                 th_fall;

	assign th_fall = th_d & ~th;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			tmr     <= '0;
			th_d    <= 1'b0;
			pad_idx <= 2'd0;
		end else begin
			if (ce_cpu) begin
				// Timer saturates just past the timeout
				if (tmr > cart_io_pkg::TAP_TIMEOUT)
					pad_idx <= 2'd0;
				else if (th)
					tmr <= tmr + 1'b1;

				th_d <= th;

				if (th_fall) begin
					tmr <= '0;
					// Edge ending a long high period starts a new scan
					if (tmr < cart_io_pkg::TAP_TIMEOUT)
						pad_idx <= pad_idx + 1'b1;
				end
			end

			if (!multitap_en)
				pad_idx <= 2'd0; // Single pad on port A
		end
	end

endmodule

// ==== hw/cheat_loader.sv ====
/*
 * Builds one cheat record from a 16-byte download.
 * Bytes land in the record's byte view at their download address, and a
 * one-cycle strobe follows the last byte so the consumer reads the fields.
 */

module cheat_loader (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  cart_io_pkg::byte_load_t load,
	output cart_io_pkg::cheat_rec_u cheat_rec,
	output logic                    cheat_strobe
);

	logic take;
	logic last_byte;

	assign take      = load.wr & load.code_sel;
	assign last_byte = &load.addr; // Address 15 closes the record

	// ========================================================================
	// Record assembly
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (take)
			cheat_rec.bytes[load.addr] <= load.data;
	end

	// ========================================================================
	// Record strobe
	// ========================================================================

	// Record is complete the cycle the strobe is seen
	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			cheat_strobe <= 1'b0;
		else
			cheat_strobe <= take & last_byte;
	end

endmodule

// ==== hw/backup_sequencer.sv ====
/*
 * Backup RAM transfer FSM. A load or save request moves all sectors between
 * backup RAM and the SD interface, one rd or wr command per sector.
 * The host acknowledges each sector with a high pulse on sd_ack.
 */

module backup_sequencer (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  cart_io_pkg::bk_req_t req,
	input  logic                 img_writable,
	input  logic                 sd_ack,
	output cart_io_pkg::sd_cmd_t sd,
	output logic                 bk_busy,    // Transfer state
	output logic                 bk_loading
);

	logic load_d, save_d, ack_d;
	logic load_rise, save_rise;
	logic ack_rise, ack_fall;
	logic start;
	logic last_sector;

	// ========================================================================
	// Edge detection
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			load_d <= 1'b0;
			save_d <= 1'b0;
			ack_d  <= 1'b0;
		end else begin
			load_d <= req.load;
			save_d <= req.save;
			ack_d  <= sd_ack;
		end
	end

	assign load_rise = req.load & ~load_d;
	assign save_rise = req.save & ~save_d;
	assign ack_rise  = sd_ack & ~ack_d;
	assign ack_fall  = ~sd_ack & ack_d;

	assign start       = ~bk_busy & img_writable & (load_rise | save_rise);
	assign last_sector = (sd.lba == (cart_io_pkg::SECTORS - 1));

	// ========================================================================
	// Transfer FSM
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			sd         <= '0;
			bk_busy    <= 1'b0;
			bk_loading <= 1'b0;
		end else begin
			if (ack_rise) begin // Host took the command
				sd.rd <= 1'b0;
				sd.wr <= 1'b0;
			end

			if (!bk_busy) begin
				if (start) begin
					bk_busy    <= 1'b1;
					bk_loading <= load_rise; // Load wins a tie
					sd.lba     <= '0;
					sd.rd      <= load_rise;
					sd.wr      <= ~load_rise;
				end
			end else if (ack_fall) begin
				if (last_sector) begin
					bk_busy    <= 1'b0;
					bk_loading <= 1'b0;
				end else begin
					sd.lba <= sd.lba + 1'b1;
					// Same direction for the next sector
					sd.rd  <= bk_loading;
					sd.wr  <= ~bk_loading;
				end
			end
		end
	end

endmodule

// ==== hw/cart_io_top.sv ====
/*
 * Top level of the game-port and cartridge-side control logic.
 * Ties the pad router, multitap timer, cheat loader and backup sequencer
 * to the platform side.
 */

module cart_io_top (
	input  logic                                           clk_sys,
	input  logic                                           rst_n,
	input  logic                                           ce_cpu,
	input  cart_io_pkg::pad_cfg_t                          cfg,
	input  cart_io_pkg::pad_t [cart_io_pkg::PAD_COUNT-1:0] pads,
	input  logic [cart_io_pkg::DB9_BITS-1:0]               db9,
	input  logic                                           th,
	input  cart_io_pkg::byte_load_t                        load,
	input  cart_io_pkg::bk_req_t                           req,
	input  logic                                           img_writable,
	input  logic                                           sd_ack,
	output cart_io_pkg::pad_t                              port_a,
	output cart_io_pkg::pad_t                              port_b,
	output logic                                           splitter_select,
	output cart_io_pkg::cheat_rec_u                        cheat_rec,
	output logic                                           cheat_strobe,
	output cart_io_pkg::sd_cmd_t                           sd,
	output logic                                           bk_busy,
	output logic                                           bk_loading
);

	logic [1:0] pad_idx; // Multitap pad on port A

	// ========================================================================
	// Game ports
	// ========================================================================

	multitap_timer u_tap (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.ce_cpu      (ce_cpu),
		.th          (th),
		.multitap_en (cfg.multitap_en),
		.pad_idx     (pad_idx)
	);

	pad_router u_pads (
		.clk_sys         (clk_sys),
		.rst_n           (rst_n),
		.cfg             (cfg),
		.pads            (pads),
		.db9             (db9),
		.pad_idx         (pad_idx),
		.port_a          (port_a),
		.port_b          (port_b),
		.splitter_select (splitter_select)
	);

	// ========================================================================
	// Cartridge side
	// ========================================================================

	cheat_loader u_cheat (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.load         (load),
		.cheat_rec    (cheat_rec),
		.cheat_strobe (cheat_strobe)
	);

	backup_sequencer u_backup (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.req          (req),
		.img_writable (img_writable),
		.sd_ack       (sd_ack),
		.sd           (sd),
		.bk_busy      (bk_busy),
		.bk_loading   (bk_loading)
	);

endmodule

// ==== testbench/cart_io_assertions.sv ====
/*
 * Concurrent checks on the cartridge and game-port core.
 * Bound to cart_io_top so they watch every run of the top level.
 */

module cart_io_assertions (
	input logic                  clk_sys,
	input logic                  rst_n,
	input cart_io_pkg::pad_cfg_t cfg,
	input cart_io_pkg::pad_t     port_b,
	input cart_io_pkg::sd_cmd_t  sd,
	input logic                  cheat_strobe
);

	// One SD command direction at a time
	a_one_cmd: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!(sd.rd && sd.wr))
		else $error("sd rd and wr high together");

	a_strobe_pulse: assert property (@(posedge clk_sys) disable iff (!rst_n)
		cheat_strobe |=> !cheat_strobe)
		else $error("cheat_strobe high for two cycles");

	// Port B is released while the multitap owns the ports
	a_tap_port_b: assert property (@(posedge clk_sys) disable iff (!rst_n)
		cfg.multitap_en |=> (&port_b))
		else $error("port_b not all ones with multitap enabled");

endmodule

bind cart_io_top cart_io_assertions u_assertions (
	.clk_sys      (clk_sys),
	.rst_n        (rst_n),
	.cfg          (cfg),
	.port_b       (port_b),
	.sd           (sd),
	.cheat_strobe (cheat_strobe)
);

// ==== testbench/cart_io_tb.sv ====
/*
 * Directed testbench for the cartridge and game-port control core.
 * Runs pad routing, splitter, multitap, cheat record and backup RAM tests
 * in turn, then prints a summary line and the overall status.
 */

module cart_io_tb;

	localparam int TEST_CYCLES = 70000; // Multitap timeout plus both transfers
	localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

	logic                                           clk_sys = 1'b0;
	logic                                           rst_n;
	logic                                           ce_cpu;
	cart_io_pkg::pad_cfg_t                          cfg;
	cart_io_pkg::pad_t [cart_io_pkg::PAD_COUNT-1:0] pads;
	logic [cart_io_pkg::DB9_BITS-1:0]               db9;
	logic                                           th;
	cart_io_pkg::byte_load_t                        load;
	cart_io_pkg::bk_req_t                           req;
	logic                                           img_writable;
	logic                                           sd_ack;
	cart_io_pkg::pad_t                              port_a, port_b;
	logic                                           splitter_select;
	cart_io_pkg::cheat_rec_u                        cheat_rec;
	logic                                           cheat_strobe;
	cart_io_pkg::sd_cmd_t                           sd;
	logic                                           bk_busy, bk_loading;

	integer seed = 32'hd948_a564;
	int     cycle_count = 0;
	int     strobe_count = 0;
	int     errors = 0;
	int     checks = 0;
	int     tests = 0;

	cart_io_top u_dut (.*);

	always #5 clk_sys = ~clk_sys;

	always @(negedge clk_sys)
		if (cheat_strobe)
			strobe_count++;

	always @(posedge clk_sys) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: run stopped after %0d cycles", cycle_count);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// ========================================================================
	// Helpers and compare tasks
	// ========================================================================

	task automatic wait_clocks(input int n);
		repeat (n) @(posedge clk_sys);
		#1; // Drive just after the edge
	endtask

	function automatic cart_io_pkg::pad_t rand_pad();
		logic [31:0] r;
		r = $random(seed);
		return r[cart_io_pkg::PAD_BITS-1:0];
	endfunction

	task automatic check_pad(input string name, input cart_io_pkg::pad_t want,
		input cart_io_pkg::pad_t got);
		checks++;
		if (got !== want) begin
			errors++;
			$display("ERR %s: expected %b, got %b", name, want, got);
		end
	endtask

	task automatic check_cheat(input string name, input cart_io_pkg::cheat_fields_t want,
		input cart_io_pkg::cheat_fields_t got);
		checks++;
		if (got !== want) begin
			errors++;
			$display("ERR %s: expected %h, got %h", name, want, got);
		end
	endtask

	task automatic check_sd(input string name, input cart_io_pkg::sd_cmd_t want,
		input cart_io_pkg::sd_cmd_t got);
		checks++;
		if (got !== want) begin
			errors++;
			$display("ERR %s: expected lba %0d rd %b wr %b, got lba %0d rd %b wr %b",
				name, want.lba, want.rd, want.wr, got.lba, got.rd, got.wr);
		end
	endtask

	task automatic check_bit(input string name, input logic want, input logic got);
		checks++;
		if (got !== want) begin
			errors++;
			$display("ERR %s: expected %b, got %b", name, want, got);
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests++;
		if (errors == errors_before)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errors - errors_before);
	endtask

	// ========================================================================
	// Directed tests
	// ========================================================================

	task automatic test_pad_routing();
		cart_io_pkg::pad_t p0, p1;
		logic [31:0]       r;
		int                e0;
		e0 = errors;
		for (int m = 0; m < 3; m++) begin
			for (int sw = 0; sw < 2; sw++) begin
				for (int rep = 0; rep < 4; rep++) begin
					for (int i = 0; i < cart_io_pkg::PAD_COUNT; i++)
						pads[i] = rand_pad();
					r = $random(seed);
					db9 = r[cart_io_pkg::DB9_BITS-1:0];
					cfg.db9_mode = (m == 0) ? cart_io_pkg::DB9_P1 :
						(m == 1) ? cart_io_pkg::DB9_P2 : cart_io_pkg::DB9_OFF;
					cfg.swap = sw[0];
					cfg.multitap_en = 1'b0;
					p0 = pads[0];
					p1 = pads[1];
					if (m == 0)
						p0 = p0 | {1'b0, db9};
					if (m == 1)
						p1 = p1 | {1'b0, db9};
					wait_clocks(2);
					check_pad("pad routing port a", sw ? ~p1 : ~p0, port_a);
					check_pad("pad routing port b", sw ? ~p0 : ~p1, port_b);
				end
			end
		end
		report_test("pad routing", e0);
	endtask

	task automatic test_splitter();
		logic [31:0]                      r;
		logic [cart_io_pkg::DB9_BITS-1:0] hi_word, lo_word;
		int                               e0;
		int                               pos;
		e0 = errors;
		r = $random(seed);
		hi_word = r[cart_io_pkg::DB9_BITS-1:0];
		lo_word = ~hi_word; // Must differ from the high word
		pads = '0;
		cfg.db9_mode = cart_io_pkg::DB9_SPLIT;
		cfg.swap = 1'b0;
		cfg.multitap_en = 1'b0;
		for (int n = 0; n < 4 * cart_io_pkg::SPLIT_PERIOD + 4; n++) begin
			pos = n % cart_io_pkg::SPLIT_PERIOD;
			// High out of reset, flips on every prescaler wrap
			if (pos == 0 || pos == cart_io_pkg::SPLIT_PERIOD - 1)
				check_bit("splitter select", (n / cart_io_pkg::SPLIT_PERIOD) % 2 == 0,
					splitter_select);
			db9 = splitter_select ? hi_word : lo_word;
			wait_clocks(1);
		end
		check_pad("splitter port a", ~{1'b0, hi_word}, port_a);
		check_pad("splitter port b", ~{1'b0, lo_word}, port_b);
		cfg.db9_mode = cart_io_pkg::DB9_OFF;
		wait_clocks(2);
		report_test("splitter", e0);
	endtask

	task automatic test_multitap();
		int e0;
		e0 = errors;
		for (int i = 0; i < cart_io_pkg::PAD_COUNT; i++)
			pads[i] = rand_pad();
		db9 = '0;
		cfg.db9_mode = cart_io_pkg::DB9_OFF;
		cfg.swap = 1'b0;
		cfg.multitap_en = 1'b1;
		th = 1'b0;
		wait_clocks(3);
		check_pad("multitap pad 0", ~pads[0], port_a);
		check_pad("multitap port b", '1, port_b);
		for (int k = 1; k < cart_io_pkg::PAD_COUNT; k++) begin
			th = 1'b1; // Short TH pulse
			wait_clocks(4);
			th = 1'b0;
			wait_clocks(3);
			check_pad($sformatf("multitap pad %0d", k), ~pads[k], port_a);
		end
		th = 1'b1;
		wait_clocks(int'(cart_io_pkg::TAP_TIMEOUT) + 8);
		check_pad("multitap timeout", ~pads[0], port_a);
		th = 1'b0;
		wait_clocks(3);
		check_pad("multitap rescan", ~pads[0], port_a);
		cfg.multitap_en = 1'b0;
		wait_clocks(2);
		report_test("multitap", e0);
	endtask

	task automatic test_cheat();
		logic [7:0]                 bytes [16];
		logic [31:0]                r;
		cart_io_pkg::cheat_fields_t want;
		int                         e0;
		e0 = errors;
		strobe_count = 0;
		for (int i = 0; i < 16; i++) begin
			r = $random(seed);
			bytes[i] = r[7:0];
			load.wr = 1'b1;
			load.code_sel = 1'b1;
			load.addr = i[3:0];
			load.data = bytes[i];
			wait_clocks(1);
		end
		load.wr = 1'b0;
		// Four little-endian words with replace in bytes 0 to 3
		want.replace = {bytes[3], bytes[2], bytes[1], bytes[0]};
		want.compare = {bytes[7], bytes[6], bytes[5], bytes[4]};
		want.address = {bytes[11], bytes[10], bytes[9], bytes[8]};
		want.flags   = {bytes[15], bytes[14], bytes[13], bytes[12]};
		check_bit("cheat strobe", 1'b1, cheat_strobe);
		check_cheat("cheat record", want, cheat_rec.fields);
		for (int i = 0; i < 16; i++) begin
			r = $random(seed);
			load.wr = 1'b1;
			load.code_sel = 1'b0; // Other download target
			load.addr = i[3:0];
			load.data = r[7:0];
			wait_clocks(1);
		end
		load.wr = 1'b0;
		wait_clocks(3);
		check_cheat("cheat ignored writes", want, cheat_rec.fields);
		checks++;
		if (strobe_count != 1) begin
			errors++;
			$display("Cheat record gave %0d strobes instead of exactly one", strobe_count);
		end
		report_test("cheat record", e0);
	endtask

	task automatic run_transfer(input string name, input logic is_load);
		cart_io_pkg::sd_cmd_t want;
		int                   n;
		img_writable = 1'b1;
		req.load = is_load;
		req.save = !is_load;
		wait_clocks(1);
		req = '0;
		for (int s = 0; s < cart_io_pkg::SECTORS; s++) begin
			n = 0;
			while (!(sd.rd || sd.wr) && n < 16) begin
				wait_clocks(1);
				n++;
			end
			if (n == 16) begin
				errors++;
				$display("%s: no SD command issued for sector %0d", name, s);
				return;
			end
			want.lba = s[cart_io_pkg::LBA_BITS-1:0];
			want.rd  = is_load;
			want.wr  = !is_load;
			check_sd(name, want, sd);
			check_bit({name, " busy"}, 1'b1, bk_busy);
			check_bit({name, " loading"}, is_load, bk_loading);
			sd_ack = 1'b1; // Host latency varies per sector
			wait_clocks(1);
			want.rd = 1'b0;
			want.wr = 1'b0;
			check_sd({name, " ack"}, want, sd); // Command dropped once acked
			if (s % 3 != 0)
				wait_clocks(s % 3);
			sd_ack = 1'b0;
		end
		n = 0;
		while (bk_busy && n < 8) begin
			wait_clocks(1);
			n++;
		end
		check_bit({name, " done"}, 1'b0, bk_busy);
		check_bit({name, " loading done"}, 1'b0, bk_loading);
	endtask

	task automatic test_backup();
		int e0;
		e0 = errors;
		run_transfer("backup load", 1'b1);
		run_transfer("backup save", 1'b0);
		img_writable = 1'b0;
		req.save = 1'b1;
		wait_clocks(1);
		req.save = 1'b0;
		wait_clocks(3);
		check_bit("backup not writable", 1'b0, bk_busy);
		img_writable = 1'b1;
		report_test("backup load and save", e0);
	endtask

	// ========================================================================
	// Main sequence
	// ========================================================================

	initial begin
		rst_n = 1'b0;
		ce_cpu = 1'b1; // CPU clock enable held on
		cfg = '0;
		pads = '0;
		db9 = '0;
		th = 1'b0;
		load = '0;
		req = '0;
		img_writable = 1'b1;
		sd_ack = 1'b0;
		wait_clocks(3);
		rst_n = 1'b1;
		wait_clocks(1);

		test_pad_routing();
		test_splitter();
		test_multitap();
		test_cheat();
		test_backup();

		$display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== sim.f ====
hw/cart_io_pkg.sv
hw/pad_router.sv
hw/multitap_timer.sv
hw/cheat_loader.sv
hw/backup_sequencer.sv
hw/cart_io_top.sv
testbench/cart_io_assertions.sv
testbench/cart_io_tb.sv
